/* common/isa_pkg.sv */
package isa_pkg;

    // --------------------
    // Address and instruction geometry
    // --------------------

    // Width of an instruction address
    localparam int ADDR_BITS = 32;

    // Byte address of an instruction word
    typedef logic [ADDR_BITS-1:0] addr_t;

    // One instruction per fetch word, fixed size
    localparam int unsigned INSTR_BYTES = 4;

    // Low PC bits that are always zero for an aligned word
    localparam int PC_LSB = $clog2(INSTR_BYTES);

    // Step between two sequential fetch addresses
    localparam addr_t PC_STEP = addr_t'(INSTR_BYTES);

endpackage

/* common/bp_pkg.sv */
package bp_pkg;

    // --------------------
    // Two-bit saturating counter
    // --------------------

    // Top bit is the taken prediction
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_t;

    // Every counter starts just below the taken threshold
    localparam counter_t COUNTER_RESET = CNT_WEAK_NT;

    // --------------------
    // Resolve report from execute
    // --------------------

    // Fetch-time history comes on its own port, its width is a module parameter
    typedef struct packed {
        logic           valid;
        logic           mispredict;
        logic           taken;
        isa_pkg::addr_t pc;
        isa_pkg::addr_t target;
    } resolve_t;

    // --------------------
    // Counter helpers
    // --------------------

    // Prediction carried by a counter state
    function automatic logic counter_predict(counter_t state);
        return state[1];
    endfunction

    // One training step toward the real outcome, saturating at both ends
    function automatic counter_t counter_next(counter_t state, logic taken);
        counter_t next_state;
        case (state)
            CNT_STRONG_NT: next_state = taken ? CNT_WEAK_NT  : CNT_STRONG_NT;
            CNT_WEAK_NT:   next_state = taken ? CNT_WEAK_T   : CNT_STRONG_NT;
            CNT_WEAK_T:    next_state = taken ? CNT_STRONG_T : CNT_WEAK_NT;
            CNT_STRONG_T:  next_state = taken ? CNT_STRONG_T : CNT_WEAK_T;
            default:       next_state = COUNTER_RESET;
        endcase
        return next_state;
    endfunction

endpackage

/* gshare/gshare.sv */
module gshare #(
    parameter int HISTORY_BITS = 8
) (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch side
    input  isa_pkg::addr_t          fetch_pc_i,
    input  logic                    branch_fetched_i,

    // Execute side
    input  bp_pkg::resolve_t        resolve_i,
    input  logic [HISTORY_BITS-1:0] resolve_history_i,

    // Prediction for the word at fetch_pc_i
    output logic                    counter_taken_o,
    output logic [HISTORY_BITS-1:0] history_o
);
    import isa_pkg::*;
    import bp_pkg::*;

    // One counter per history pattern
    localparam int TABLE_SIZE = 1 << HISTORY_BITS;

    counter_t                counter_table_q [TABLE_SIZE];

    // Speculative global history, newest outcome in bit 0
    logic [HISTORY_BITS-1:0] history_q;
    logic [HISTORY_BITS-1:0] history_d;

    logic [HISTORY_BITS-1:0] fetch_index;
    logic [HISTORY_BITS-1:0] resolve_index;
    counter_t                fetch_counter;
    counter_t                resolve_counter;
    counter_t                trained_counter;
    logic                    recover;

    // --------------------
    // Prediction
    // --------------------

    // Word bits of the PC hashed with the history
    assign fetch_index = fetch_pc_i[PC_LSB +: HISTORY_BITS] ^ history_q;
    assign fetch_counter = counter_table_q[fetch_index];

    // Raw counter prediction, the branch hint is applied in fetch
    assign counter_taken_o = counter_predict(fetch_counter);

    // History that produced this prediction, carried down the pipe
    assign history_o = history_q;

    // --------------------
    // History update
    // --------------------

    assign recover = resolve_i.valid & resolve_i.mispredict;

    always_comb begin
        history_d = history_q;
        if (recover) begin
            // Rebuild from the fetch-time history of the bad branch
            // and append what it really did
            history_d = {resolve_history_i[HISTORY_BITS-2:0], resolve_i.taken};
        end else if (branch_fetched_i) begin
            // Speculate with our own prediction
            history_d = {history_q[HISTORY_BITS-2:0], counter_taken_o};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history_q <= '0;
        end else begin
            history_q <= history_d;
        end
    end

    // --------------------
    // Counter training
    // --------------------

    // Same hash as at fetch, with the history the branch saw back then
    assign resolve_index = resolve_i.pc[PC_LSB +: HISTORY_BITS] ^ resolve_history_i;
    assign resolve_counter = counter_table_q[resolve_index];
    assign trained_counter = counter_next(resolve_counter, resolve_i.taken);

    // Every resolve trains, mispredicted or not
    always_ff @(posedge clock) begin
        if (reset) begin
            counter_table_q <= '{default: COUNTER_RESET};
        end else if (resolve_i.valid) begin
            counter_table_q[resolve_index] <= trained_counter;
        end
    end

endmodule

/* btb/btb.sv */
module btb #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic             clock,
    input  logic             reset,

    // Lookup at fetch
    input  isa_pkg::addr_t   fetch_pc_i,

    // Writes come from taken resolves
    input  bp_pkg::resolve_t resolve_i,

    output logic             hit_o,
    output isa_pkg::addr_t   target_o
);
    import isa_pkg::*;

    // --------------------
    // Geometry
    // --------------------

    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);

    // Whatever the index and word offset leave over
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - PC_LSB;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        addr_t               target;
    } btb_entry_t;

    // Tag and target per entry, liveness kept apart in valid_q
    btb_entry_t             entries_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    logic [INDEX_BITS-1:0]  fetch_index;
    logic [TAG_BITS-1:0]    fetch_tag;
    btb_entry_t             fetch_entry;

    logic [INDEX_BITS-1:0]  write_index;
    btb_entry_t             write_entry;
    logic                   write_en;

    // --------------------
    // Lookup
    // --------------------

    assign fetch_index = fetch_pc_i[PC_LSB +: INDEX_BITS];
    assign fetch_tag   = fetch_pc_i[ADDR_BITS-1 -: TAG_BITS];
    assign fetch_entry = entries_q[fetch_index];

    // Hit needs a live entry with the same upper PC bits
    assign hit_o    = valid_q[fetch_index] & (fetch_entry.tag == fetch_tag);
    assign target_o = fetch_entry.target;

    // --------------------
    // Update
    // --------------------

    // Not-taken branches never need a target
    assign write_en    = resolve_i.valid & resolve_i.taken;
    assign write_index = resolve_i.pc[PC_LSB +: INDEX_BITS];

    always_comb begin
        write_entry.tag    = resolve_i.pc[ADDR_BITS-1 -: TAG_BITS];
        write_entry.target = resolve_i.target;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[write_index] <= 1'b1;
        end
    end

    // Aliasing entries simply overwrite each other
    always_ff @(posedge clock) begin
        if (write_en) begin
            entries_q[write_index] <= write_entry;
        end
    end

endmodule

/* rtl/fetch_pc_gen.sv */
module fetch_pc_gen #(
    parameter isa_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic             clock,
    input  logic             reset,

    // Pipeline control and predecode
    input  logic             fetch_stall_i,
    input  logic             fetch_is_branch_i,

    // Predictor lookups for the current PC
    input  logic             counter_taken_i,
    input  logic             btb_hit_i,
    input  isa_pkg::addr_t   btb_target_i,

    // Execute side
    input  bp_pkg::resolve_t resolve_i,

    output isa_pkg::addr_t   fetch_pc_o,
    output logic             fetch_taken_o,
    output logic             branch_fetched_o
);
    import isa_pkg::*;

    addr_t fetch_pc_q;
    addr_t fetch_pc_d;
    addr_t seq_pc;
    addr_t recover_pc;
    logic  branch_fetched;
    logic  mispredict;
    logic  predict_redirect;

    // --------------------
    // Prediction gating
    // --------------------

    // A branch leaves fetch only when not stalled
    assign branch_fetched = fetch_is_branch_i & ~fetch_stall_i;
    assign branch_fetched_o = branch_fetched;

    // Counter opinion only counts for branch words
    assign fetch_taken_o = fetch_is_branch_i & counter_taken_i;

    // Taken without a known target falls through
    assign predict_redirect = branch_fetched & counter_taken_i & btb_hit_i;

    // --------------------
    // Next PC
    // --------------------

    assign mispredict = resolve_i.valid & resolve_i.mispredict;
    assign seq_pc     = fetch_pc_q + PC_STEP;

    // Correct path after the bad branch
    assign recover_pc = resolve_i.taken ? resolve_i.target : resolve_i.pc + PC_STEP;

    always_comb begin
        if (mispredict) begin
            // Recovery wins over everything, stall included
            fetch_pc_d = recover_pc;
        end else if (fetch_stall_i) begin
            fetch_pc_d = fetch_pc_q;
        end else if (predict_redirect) begin
            fetch_pc_d = btb_target_i;
        end else begin
            fetch_pc_d = seq_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc_q <= RESET_PC;
        end else begin
            fetch_pc_q <= fetch_pc_d;
        end
    end

    assign fetch_pc_o = fetch_pc_q;

endmodule

/* rtl/branch_predictor.sv */
module branch_predictor #(
    parameter int             HISTORY_BITS = 8,
    parameter int             BTB_ENTRIES  = 16,
    parameter isa_pkg::addr_t RESET_PC     = 32'h0000_1000
) (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch control
    input  logic                    fetch_stall_i,
    input  logic                    fetch_is_branch_i,

    // Resolved branch from execute
    input  bp_pkg::resolve_t        resolve_i,
    input  logic [HISTORY_BITS-1:0] resolve_history_i,

    // Prediction for the current fetch word
    output isa_pkg::addr_t          fetch_pc_o,
    output logic                    fetch_taken_o,
    output logic [HISTORY_BITS-1:0] fetch_history_o
);
    import isa_pkg::*;

    // --------------------
    // Internal wires
    // --------------------

    logic  branch_fetched;
    logic  counter_taken;
    logic  btb_hit;
    addr_t btb_target;

    // PC register and redirect priority
    fetch_pc_gen #(
        .RESET_PC          (RESET_PC)
    ) i_fetch_pc_gen (
        .clock             (clock),
        .reset             (reset),
        .fetch_stall_i     (fetch_stall_i),
        .fetch_is_branch_i (fetch_is_branch_i),
        .counter_taken_i   (counter_taken),
        .btb_hit_i         (btb_hit),
        .btb_target_i      (btb_target),
        .resolve_i         (resolve_i),
        .fetch_pc_o        (fetch_pc_o),
        .fetch_taken_o     (fetch_taken_o),
        .branch_fetched_o  (branch_fetched)
    );

    // Direction
    gshare #(
        .HISTORY_BITS      (HISTORY_BITS)
    ) i_gshare (
        .clock             (clock),
        .reset             (reset),
        .fetch_pc_i        (fetch_pc_o),
        .branch_fetched_i  (branch_fetched),
        .resolve_i         (resolve_i),
        .resolve_history_i (resolve_history_i),
        .counter_taken_o   (counter_taken),
        .history_o         (fetch_history_o)
    );

    // Target
    btb #(
        .BTB_ENTRIES       (BTB_ENTRIES)
    ) i_btb (
        .clock             (clock),
        .reset             (reset),
        .fetch_pc_i        (fetch_pc_o),
        .resolve_i         (resolve_i),
        .hit_o             (btb_hit),
        .target_o          (btb_target)
    );

endmodule

/* bench/branch_predictor_checker.sv */
module branch_predictor_checker #(
    parameter int HISTORY_BITS = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_stall_i,
    input  bp_pkg::resolve_t        resolve_i,
    input  logic [HISTORY_BITS-1:0] resolve_history_i,
    input  isa_pkg::addr_t          fetch_pc_i,
    input  logic [HISTORY_BITS-1:0] fetch_history_i
);
    import isa_pkg::*;

    logic                    recover;
    logic [HISTORY_BITS-1:0] restored_history;

    assign recover = resolve_i.valid & resolve_i.mispredict;

    // History the predictor must hold one edge after a mispredict
    assign restored_history = {resolve_history_i[HISTORY_BITS-2:0], resolve_i.taken};

    // --------------------
    // Fetch PC
    // --------------------

    pc_aligned: assert property (@(posedge clock) disable iff (reset)
        fetch_pc_i[PC_LSB-1:0] == '0)
        else $error("fetch PC lost word alignment");

    // Stall freezes the PC unless execute redirects
    pc_held: assert property (@(posedge clock) disable iff (reset)
        (fetch_stall_i && !recover) |=> (fetch_pc_i == $past(fetch_pc_i)))
        else $error("fetch PC moved while stalled");

    // --------------------
    // Global history
    // --------------------

    history_restored: assert property (@(posedge clock) disable iff (reset)
        recover |=> (fetch_history_i == $past(restored_history)))
        else $error("history not restored after mispredict");

endmodule

bind branch_predictor branch_predictor_checker #(
    .HISTORY_BITS      (HISTORY_BITS)
) i_branch_predictor_checker (
    .clock             (clock),
    .reset             (reset),
    .fetch_stall_i     (fetch_stall_i),
    .resolve_i         (resolve_i),
    .resolve_history_i (resolve_history_i),
    .fetch_pc_i        (fetch_pc_o),
    .fetch_history_i   (fetch_history_o)
);

/* bench/branch_predictor_tb.sv */
module branch_predictor_tb;
    import isa_pkg::*;
    import bp_pkg::*;

    localparam int    HISTORY_BITS  = 8;
    localparam addr_t RESET_PC      = 32'h0000_1000;
    localparam int    RANDOM_CYCLES = 4000;

    logic                    clock;
    logic                    reset;
    logic                    fetch_stall;
    logic                    fetch_is_branch;
    resolve_t                resolve;
    logic [HISTORY_BITS-1:0] resolve_history;
    addr_t                   fetch_pc;
    logic                    fetch_taken;
    logic [HISTORY_BITS-1:0] fetch_history;

    // Reference model sized for the default parameters
    logic [1:0]  model_ctr [256];
    addr_t       model_pc;
    logic [7:0]  model_hist;
    logic        model_btb_valid [16];
    logic [25:0] model_btb_tag [16];
    addr_t       model_btb_target [16];

    logic [31:0] lfsr_state;
    int          error_count;
    int          timeout_count;
    int          redirect_count;
    int          stalled_recover_count;
    int          saturate_taken_count;
    int          saturate_not_taken_count;

    branch_predictor i_branch_predictor (
        .clock             (clock),
        .reset             (reset),
        .fetch_stall_i     (fetch_stall),
        .fetch_is_branch_i (fetch_is_branch),
        .resolve_i         (resolve),
        .resolve_history_i (resolve_history),
        .fetch_pc_o        (fetch_pc),
        .fetch_taken_o     (fetch_taken),
        .fetch_history_o   (fetch_history)
    );

    always #10 clock = ~clock;

    // --------------------
    // Random source
    // --------------------

    // Right-shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Two groups of eight words that share BTB indexes but differ in tag
    function automatic addr_t pool_pc(input logic [3:0] pick);
        return RESET_PC + {25'd0, pick[3], 1'b0, pick[2:0], 2'b00};
    endfunction

    // Saturating two-bit counter step
    function automatic logic [1:0] counter_step(input logic [1:0] state, input logic taken);
        if (taken) begin
            return (state == 2'b11) ? state : state + 2'd1;
        end
        return (state == 2'b00) ? state : state - 2'd1;
    endfunction

    // --------------------
    // Checks and model
    // --------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            error_count++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic reset_model;
        for (int i = 0; i < 256; i++) begin
            model_ctr[i] = COUNTER_RESET;
        end
        for (int i = 0; i < 16; i++) begin
            model_btb_valid[i] = 1'b0;
            model_btb_tag[i] = '0;
            model_btb_target[i] = '0;
        end
        model_pc = RESET_PC;
        model_hist = '0;
    endtask

    // Starts at posedge + 2 and returns at the next posedge + 2
    task automatic run_cycle(input logic stall, input logic branch, input resolve_t res,
                             input logic [7:0] res_history);
        logic [7:0] fetch_index;
        logic [7:0] train_index;
        logic [3:0] btb_index;
        logic [3:0] write_index;
        logic       predict;
        logic       hit;
        logic       fetched;
        logic       recover;
        addr_t      next_pc;
        logic [7:0] next_hist;
        fetch_stall = stall;
        fetch_is_branch = branch;
        resolve = res;
        resolve_history = res_history;
        // Combinational outputs are sampled mid-cycle
        @(negedge clock);
        fetch_index = model_pc[9:2] ^ model_hist;
        predict = model_ctr[fetch_index][1];
        btb_index = model_pc[5:2];
        hit = model_btb_valid[btb_index] && (model_btb_tag[btb_index] == model_pc[31:6]);
        check_value("fetch_pc_o", fetch_pc, model_pc);
        check_value("fetch_history_o", {24'd0, fetch_history}, {24'd0, model_hist});
        check_value("fetch_taken_o", {31'd0, fetch_taken}, {31'd0, branch & predict});
        fetched = branch & ~stall;
        recover = res.valid & res.mispredict;
        // Redirect priority is mispredict, then stall, then BTB, then sequential
        if (recover) begin
            next_pc = res.taken ? res.target : res.pc + 32'd4;
            if (stall) begin
                stalled_recover_count++;
            end
        end else if (stall) begin
            next_pc = model_pc;
        end else if (fetched && predict && hit) begin
            next_pc = model_btb_target[btb_index];
            redirect_count++;
        end else begin
            next_pc = model_pc + 32'd4;
        end
        if (recover) begin
            next_hist = {res_history[6:0], res.taken};
        end else if (fetched) begin
            next_hist = {model_hist[6:0], predict};
        end else begin
            next_hist = model_hist;
        end
        @(posedge clock);
        #2;
        model_pc = next_pc;
        model_hist = next_hist;
        train_index = res.pc[9:2] ^ res_history;
        write_index = res.pc[5:2];
        if (res.valid) begin
            if (res.taken && model_ctr[train_index] == 2'b11) begin
                saturate_taken_count++;
            end
            if (!res.taken && model_ctr[train_index] == 2'b00) begin
                saturate_not_taken_count++;
            end
            model_ctr[train_index] = counter_step(model_ctr[train_index], res.taken);
        end
        if (res.valid && res.taken) begin
            model_btb_valid[write_index] = 1'b1;
            model_btb_tag[write_index] = res.pc[31:6];
            model_btb_target[write_index] = res.target;
        end
    endtask

    task automatic random_cycle;
        logic [31:0] bits;
        logic        stall;
        logic        branch;
        resolve_t    res;
        take_bits(2, bits);
        stall = (bits[1:0] == 2'b00);
        take_bits(1, bits);
        branch = bits[0];
        take_bits(1, bits);
        res.valid = bits[0];
        take_bits(1, bits);
        res.taken = bits[0];
        take_bits(3, bits);
        res.mispredict = (bits[2:0] == 3'b000);
        take_bits(4, bits);
        res.pc = pool_pc(bits[3:0]);
        take_bits(4, bits);
        res.target = pool_pc(bits[3:0]);
        // Small history pool so counters saturate
        take_bits(3, bits);
        run_cycle(stall, branch, res, {5'd0, bits[2:0]});
    endtask

    task automatic wait_for_pc(input addr_t target, input int limit);
        int waited;
        waited = 0;
        while (fetch_pc !== target && waited < limit) begin
            run_cycle(1'b0, 1'b0, '0, 8'd0);
            waited++;
        end
        assert (fetch_pc === target) else begin
            timeout_count++;
            $display("Fetch PC did not reach %h within %0d cycles", target, limit);
        end
    endtask

    task automatic require_seen(input string what, input int count);
        assert (count > 0) else begin
            error_count++;
            $display("Random stimulus never produced %s", what);
        end
    endtask

    // --------------------
    // Sequence
    // --------------------

    initial begin
        logic [31:0] bits;
        clock = 1'b0;
        reset = 1'b1;
        fetch_stall = 1'b0;
        fetch_is_branch = 1'b0;
        resolve = '0;
        resolve_history = '0;
        lfsr_state = 32'h6a8b;
        error_count = 0;
        timeout_count = 0;
        redirect_count = 0;
        stalled_recover_count = 0;
        saturate_taken_count = 0;
        saturate_not_taken_count = 0;
        reset_model();
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        check_value("fetch_pc_o", fetch_pc, RESET_PC);
        check_value("fetch_history_o", {24'd0, fetch_history}, 32'd0);
        // Branch hint under stall while every counter is still not-taken
        run_cycle(1'b1, 1'b1, '0, 8'd0);
        // Sequential stepping with random stall
        for (int i = 0; i < 24; i++) begin
            take_bits(2, bits);
            run_cycle(bits[1:0] == 2'b00, 1'b0, '0, 8'd0);
        end
        wait_for_pc(model_pc + 32'd32, 20);
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_cycle();
        end
        require_seen("a BTB redirect", redirect_count);
        require_seen("a mispredict while stalled", stalled_recover_count);
        require_seen("a counter saturated at strong taken", saturate_taken_count);
        require_seen("a counter saturated at strong not-taken", saturate_not_taken_count);
        $display("Error counts: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* branch_predictor.f */
common/isa_pkg.sv
common/bp_pkg.sv
gshare/gshare.sv
btb/btb.sv
rtl/fetch_pc_gen.sv
rtl/branch_predictor.sv
bench/branch_predictor_checker.sv
bench/branch_predictor_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Done: errors found"

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f branch_predictor.f \
    -o sim_branch_predictor
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_branch_predictor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
echo "Result: PASS"
exit 0
